//--- run.sh
#!/bin/sh
# Build and run the sideband transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps --top-module sb_tx_tb -f sb_tx.f

# Assertion errors must not stop the run before the testbench reports
out=$(./obj_dir/Vsb_tx_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"

//--- sb_arbiter.sv
// LT frames win when both peers wait; a started frame keeps the line until its last symbol
`timescale 1ns/100ps

module sb_arbiter (
  input  logic ELEC_vif,
  input  logic reset,
  sb_symbol_if.consumer at_sym,
  sb_symbol_if.consumer lt_sym,
  sb_symbol_if.producer ser_sym
);

  logic locked;     // A frame owns the serializer
  logic grant_lt;   // Owner when locked
  logic sel_lt;

  // Priority only applies between frames
  assign sel_lt = locked ? grant_lt : lt_sym.valid;

  assign ser_sym.valid = sel_lt ? lt_sym.valid : at_sym.valid;
  assign ser_sym.sym   = sel_lt ? lt_sym.sym   : at_sym.sym;
  assign ser_sym.last  = sel_lt ? lt_sym.last  : at_sym.last;

  assign lt_sym.ready  = sel_lt  && ser_sym.ready;
  assign at_sym.ready  = !sel_lt && ser_sym.ready;

  ////////////////////////////////////////////////////////////////////////////
  // Lock engages on the first offered symbol so the offer cannot change
  // under the serializer, and releases with the transfer carrying last
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ELEC_vif) begin
    if (reset) begin
      locked   <= 1'b0;
      grant_lt <= 1'b0;
    end else if (ser_sym.valid) begin
      locked   <= !(ser_sym.ready && ser_sym.last);
      grant_lt <= sel_lt;
    end
  end

endmodule

//--- sb_at_framer.sv
// One AT frame at a time; the request fields are sampled only in the cycle the request is accepted
`timescale 1ns/100ps

module sb_at_framer import sb_pkg::*; (
  input  logic        ELEC_vif,
  input  logic        reset,
  input  logic        at_valid,
  output logic        at_ready,
  input  logic        at_rsp,         // 1 selects a response frame
  input  logic        at_read_write,
  input  logic [7:0]  at_address,
  input  logic [6:0]  at_len,
  input  logic [23:0] at_data,
  sb_symbol_if.producer sym
);

  logic        busy;
  logic [3:0]  idx;         // Position of the presented symbol in the frame
  logic [3:0]  crc_lo_idx;  // Where the CRC low byte sits
  logic        accept;
  logic        xfer;

  logic        rsp_q;
  sym_t        addr_q;
  sym_t        rwlen_q;
  logic [23:0] data_q;
  logic [15:0] crc_q;

  // LSB-first CRC step over one byte
  function automatic logic [15:0] crc_byte(input logic [15:0] crc_in, input sym_t data);
    logic [15:0] c;
    c = crc_in;
    for (int j = 0; j < 8; j++) begin
      if (data[j] ^ c[15]) c = (c << 1) ^ SB_CRC_POLY;
      else                 c = c << 1;
    end
    return c;
  endfunction

  function automatic sym_t bit_rev(input sym_t b);
    sym_t r;
    for (int i = 0; i < 8; i++) r[i] = b[7-i];
    return r;
  endfunction

  assign accept     = at_valid && at_ready;
  assign xfer       = sym.valid && sym.ready;
  assign at_ready   = !busy;
  assign sym.valid  = busy;
  assign crc_lo_idx = rsp_q ? 4'(4 + SB_RSP_DATA_BYTES) : 4'd4;
  assign sym.last   = (idx == crc_lo_idx + 4'd3);

  ////////////////////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ELEC_vif) begin
    if (reset) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (xfer) begin
      if (sym.last) busy <= 1'b0;   // ETX gone, ready for the next request
      idx <= idx + 4'd1;
    end
  end

  // Request capture, data shifting and the running CRC
  always_ff @(posedge ELEC_vif) begin
    if (accept) begin
      rsp_q   <= at_rsp;
      addr_q  <= at_address;
      rwlen_q <= {at_read_write, at_len};
      data_q  <= at_data;
      crc_q   <= SB_CRC_INIT;
    end else if (xfer) begin
      if (idx >= 4'd1 && idx < crc_lo_idx) crc_q <= crc_byte(crc_q, sym.sym);
      if (idx >= 4'd4 && idx < crc_lo_idx) data_q <= data_q >> 8;   // Next byte to the bottom
    end
  end

  always_comb begin
    if (idx == 4'd0)                    sym.sym = SB_DLE;
    else if (idx == 4'd1)               sym.sym = rsp_q ? SB_STX_RSP : SB_STX_CMD;
    else if (idx == 4'd2)               sym.sym = addr_q;
    else if (idx == 4'd3)               sym.sym = rwlen_q;
    else if (idx < crc_lo_idx)          sym.sym = data_q[7:0];
    else if (idx == crc_lo_idx)         sym.sym = bit_rev(crc_q[7:0]);
    else if (idx == crc_lo_idx + 4'd1)  sym.sym = bit_rev(crc_q[15:8]);
    else if (idx == crc_lo_idx + 4'd2)  sym.sym = SB_DLE;
    else                                sym.sym = SB_ETX;
  end

endmodule

//--- sb_lt_framer.sv
// Sends one three-symbol LT_fall frame per accepted request; lane is sampled at acceptance
`timescale 1ns/100ps

module sb_lt_framer import sb_pkg::*; (
  input  logic ELEC_vif,
  input  logic reset,
  input  logic lt_valid,
  output logic lt_ready,
  input  logic lt_lane,
  sb_symbol_if.producer sym
);

  logic [1:0] cnt;      // 0 is idle, 1 to 3 select the symbol on offer
  logic       lane_q;
  sym_t       lse;

  assign lt_ready  = (cnt == 2'd0);
  assign sym.valid = (cnt != 2'd0);
  assign sym.last  = (cnt == 2'd3);
  assign lse       = lane_q ? SB_LSE_LANE1 : SB_LSE_LANE0;

  always_ff @(posedge ELEC_vif) begin
    if (reset) begin
      cnt <= 2'd0;
    end else if (lt_valid && lt_ready) begin
      cnt <= 2'd1;
    end else if (sym.valid && sym.ready) begin
      cnt <= cnt + 2'd1;   // Wraps to idle after the inverted LSE
    end
  end

  always_ff @(posedge ELEC_vif) begin
    if (lt_valid && lt_ready) lane_q <= lt_lane;
  end

  always_comb begin
    case (cnt)
      2'd1:    sym.sym = SB_DLE;
      2'd2:    sym.sym = lse;
      default: sym.sym = ~lse;
    endcase
  end

endmodule

//--- sb_pkg.sv
// Shared sideband constants; bit timing assumes a clock at SB_BIT_CYCLES times the line bit rate
package sb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Symbol type and frame codes
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] sym_t;             // One sideband symbol

  localparam sym_t SB_DLE       = 8'hFE; // Data Link Escape opens every frame
  localparam sym_t SB_ETX       = 8'h40; // End of transaction
  localparam sym_t SB_STX_CMD   = 8'h05; // Start of an AT command
  localparam sym_t SB_STX_RSP   = 8'h04; // Start of an AT response

  // Lane state event codes for LT_fall
  localparam sym_t SB_LSE_LANE0 = 8'h80;
  localparam sym_t SB_LSE_LANE1 = 8'hA0;

  ////////////////////////////////////////////////////////////////////////////
  // CRC-16 over STX through the last data byte
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [15:0] SB_CRC_POLY = 16'h8005;
  localparam logic [15:0] SB_CRC_INIT = 16'hFFFF;

  ////////////////////////////////////////////////////////////////////////////
  // Line timing and frame sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int SB_BIT_CYCLES = 4;      // Clock cycles per line bit
  localparam int SB_SYM_BITS   = 10;     // Start + 8 data + stop

  // Data bytes carried by an AT response
  localparam int SB_RSP_DATA_BYTES = 3;

endpackage

//--- sb_serializer.sv
// Each symbol leaves LSB first framed by start 0 and stop 1; the line rests at 1 between symbols
`timescale 1ns/100ps

module sb_serializer import sb_pkg::*; (
  input  logic ELEC_vif,
  input  logic reset,
  sb_symbol_if.consumer sym,
  output logic sbtx
);

  logic                             busy;
  logic [SB_SYM_BITS-1:0]           shift_q;   // Bit 0 is on the line
  logic [$clog2(SB_BIT_CYCLES)-1:0] cyc_cnt;   // Cycles into the current bit
  logic [$clog2(SB_SYM_BITS)-1:0]   bit_cnt;   // Bits sent of this symbol
  logic                             bit_end;
  logic                             sym_end;

  assign bit_end = (int'(cyc_cnt) == SB_BIT_CYCLES - 1);
  assign sym_end = bit_end && (int'(bit_cnt) == SB_SYM_BITS - 1);

  // Accept while idle or on the final cycle of a stop bit
  assign sym.ready = !busy || sym_end;
  assign sbtx      = busy ? shift_q[0] : 1'b1;

  always_ff @(posedge ELEC_vif) begin
    if (reset) begin
      busy    <= 1'b0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end else if (sym.valid && sym.ready) begin
      busy    <= 1'b1;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end else if (busy) begin
      if (bit_end) begin
        cyc_cnt <= '0;
        if (sym_end) busy <= 1'b0;
        else         bit_cnt <= bit_cnt + 1'b1;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shift word
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ELEC_vif) begin
    if (sym.valid && sym.ready) begin
      shift_q <= {1'b1, sym.sym, 1'b0};   // Stop, data, start
    end else if (busy && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

//--- sb_symbol_if.sv
// One frame symbol per valid/ready transfer; sym and last hold steady while valid waits for ready
`timescale 1ns/100ps

interface sb_symbol_if import sb_pkg::*; ();

  logic valid;
  logic ready;
  sym_t sym;
  logic last;   // Final symbol of a frame

  modport producer (
    output valid, sym, last,
    input  ready
  );

  modport consumer (
    input  valid, sym, last,
    output ready
  );

endinterface

//--- sb_tx.f
sb_pkg.sv
sb_symbol_if.sv
sb_at_framer.sv
sb_lt_framer.sv
sb_arbiter.sv
sb_serializer.sv
sb_tx_top.sv
sb_tx_sva.sv
sb_tx_checker.sv
sb_tx_tb.sv

//--- sb_tx_checker.sv
// Samples sbtx at falling clock edges; needs SB_BIT_CYCLES of at least 2 to hit mid-bit
`timescale 1ns/100ps

module sb_tx_checker import sb_pkg::*; (
  input logic ELEC_vif,
  input logic reset,
  input logic sbtx,
  input logic at_ready,
  input logic lt_ready
);

  sym_t exp_q[$];               // Expected line symbols, oldest first
  int   sym_errs    = 0;
  int   bit_errs    = 0;        // Start and stop bits
  int   dle_errs    = 0;
  int   extra_errs  = 0;
  int   ready_errs  = 0;

  logic check_ready = 1'b1;     // Until the first cycle out of reset
  logic receiving   = 1'b0;
  logic after_idle;
  int   idle_cnt    = 0;
  int   t;                      // Cycles since the start bit fell
  int   k;
  sym_t rx;
  sym_t exp;

  always @(negedge ELEC_vif) begin
    ////////////////////////////////////////////////////////////////////////////
    // Reset state of the line and the request ports
    ////////////////////////////////////////////////////////////////////////////
    if (check_ready) begin
      if (at_ready !== 1'b1) begin
        ready_errs++;
        $display("ERR at_ready expected %h actual %h", 1'b1, at_ready);
      end
      if (lt_ready !== 1'b1) begin
        ready_errs++;
        $display("ERR lt_ready expected %h actual %h", 1'b1, lt_ready);
      end
      if (!reset) check_ready = 1'b0;
    end

    if (reset) begin
      if (sbtx !== 1'b1) begin
        bit_errs++;
        $display("ERR sbtx expected %h actual %h", 1'b1, sbtx);
      end
      receiving = 1'b0;
      idle_cnt  = SB_SYM_BITS;
    end else if (!receiving) begin
      if (sbtx === 1'b0) begin
        receiving  = 1'b1;
        t          = 0;
        after_idle = (idle_cnt > 1);   // More than the tail of a stop bit
        idle_cnt   = 0;
      end else begin
        idle_cnt++;
      end
    end else begin
      t++;
      if (t % SB_BIT_CYCLES == SB_BIT_CYCLES / 2) begin   // Middle of a bit
        k = t / SB_BIT_CYCLES;
        if (k == 0 && sbtx !== 1'b0) begin
          bit_errs++;
          $display("Start bit on sbtx went high before its middle");
        end else if (k >= 1 && k <= 8) begin
          rx[k-1] = sbtx;                 // LSB first
        end else if (k == SB_SYM_BITS - 1) begin
          receiving = 1'b0;
          if (sbtx !== 1'b1) begin
            bit_errs++;
            $display("ERR sbtx_stop expected %h actual %h", 1'b1, sbtx);
          end
          if (after_idle && rx !== SB_DLE) begin
            dle_errs++;
            $display("ERR sbtx_symbol expected %h actual %h after idle", SB_DLE, rx);
          end
          if (exp_q.size() == 0) begin
            extra_errs++;
            $display("Symbol %h appeared on sbtx while nothing was expected", rx);
          end else begin
            exp = exp_q.pop_front();
            if (rx !== exp) begin
              sym_errs++;
              $display("ERR sbtx_symbol expected %h actual %h", exp, rx);
            end
          end
        end
      end
    end
  end

endmodule

//--- sb_tx_sva.sv
// Bound into sb_serializer; relies on its internal busy, cyc_cnt and bit_cnt names
`timescale 1ns/100ps

module sb_tx_sva import sb_pkg::*; (
  input logic                             ELEC_vif,
  input logic                             reset,
  input logic                             sym_valid,
  input logic                             sym_ready,
  input sym_t                             sym_sym,
  input logic                             busy,
  input logic [$clog2(SB_BIT_CYCLES)-1:0] cyc_cnt,
  input logic [$clog2(SB_SYM_BITS)-1:0]   bit_cnt,
  input logic                             sbtx
);

  int fail_cnt = 0;   // Failed assertion count

  // Offered symbol holds while the serializer is busy
  a_sym_stable: assert property (@(posedge ELEC_vif) disable iff (reset)
    sym_valid && !sym_ready |=> $stable(sym_sym))
    else begin
      fail_cnt++;
      $error("sym changed while valid waited for ready");
    end

  a_reset_idle: assert property (@(posedge ELEC_vif) reset |=> sbtx)
    else begin
      fail_cnt++;
      $error("sbtx left idle level during reset");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Start bit is low for exactly SB_BIT_CYCLES cycles
  ////////////////////////////////////////////////////////////////////////////

  a_start_low: assert property (@(posedge ELEC_vif) disable iff (reset)
    busy && bit_cnt == '0 |-> !sbtx)
    else begin
      fail_cnt++;
      $error("sbtx high during start bit");
    end

  a_start_len: assert property (@(posedge ELEC_vif) disable iff (reset)
    busy && bit_cnt == '0 && int'(cyc_cnt) != SB_BIT_CYCLES - 1 |=> busy && bit_cnt == '0)
    else begin
      fail_cnt++;
      $error("start bit ended early");
    end

  a_start_end: assert property (@(posedge ELEC_vif) disable iff (reset)
    busy && bit_cnt == '0 && int'(cyc_cnt) == SB_BIT_CYCLES - 1 |=> int'(bit_cnt) == 1)
    else begin
      fail_cnt++;
      $error("start bit did not end on time");
    end

endmodule

bind sb_serializer sb_tx_sva u_sva (
  .ELEC_vif  (ELEC_vif),
  .reset     (reset),
  .sym_valid (sym.valid),
  .sym_ready (sym.ready),
  .sym_sym   (sym.sym),
  .busy      (busy),
  .cyc_cnt   (cyc_cnt),
  .bit_cnt   (bit_cnt),
  .sbtx      (sbtx)
);

//--- sb_tx_tb.sv
// A request not accepted or a symbol never seen counts as an error after a bounded wait
`timescale 1ns/100ps

module sb_tx_tb import sb_pkg::*; ();

  logic        ELEC_vif = 1'b0;
  logic        reset;
  logic        at_valid;
  logic        at_ready;
  logic        at_rsp;
  logic        at_read_write;
  logic [7:0]  at_address;
  logic [6:0]  at_len;
  logic [23:0] at_data;
  logic        lt_valid;
  logic        lt_ready;
  logic        lt_lane;
  logic        sbtx;

  sym_t        ref_q[$];               // Last frame built by sb_ref_frame
  logic [31:0] rng          = 32'h6adcbf02;
  int          wait_limit   = 4000;    // Cycles allowed for any single wait
  int          timeout_errs = 0;
  int          total_errs;

  always #50 ELEC_vif = ~ELEC_vif;

  sb_tx_top u_dut (.*);

  sb_tx_checker u_chk (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Expected frame with its CRC, symbols into ref_q
  ////////////////////////////////////////////////////////////////////////////

  function automatic void sb_ref_frame(input logic is_lt, input logic lane,
                                       input logic rsp, input logic rw,
                                       input logic [7:0] addr, input logic [6:0] len,
                                       input logic [23:0] data);
    sym_t        body[$];
    sym_t        lse;
    sym_t        crc_lo;
    sym_t        crc_hi;
    logic [15:0] crc;
    logic        fb;
    ref_q.delete();
    if (is_lt) begin
      lse = lane ? SB_LSE_LANE1 : SB_LSE_LANE0;
      ref_q.push_back(SB_DLE);
      ref_q.push_back(lse);
      ref_q.push_back(~lse);
      return;
    end
    body.push_back(rsp ? SB_STX_RSP : SB_STX_CMD);
    body.push_back(addr);
    body.push_back({rw, len});
    if (rsp) for (int i = 0; i < SB_RSP_DATA_BYTES; i++) body.push_back(data[8*i +: 8]);
    crc = SB_CRC_INIT;
    foreach (body[i]) begin
      for (int b = 0; b < 8; b++) begin   // LSB of each byte enters first
        fb  = crc[15] ^ body[i][b];
        crc = {crc[14:0], 1'b0};
        if (fb) crc = crc ^ SB_CRC_POLY;
      end
    end
    for (int b = 0; b < 8; b++) begin     // Bit-reversed CRC bytes
      crc_lo[b] = crc[7-b];
      crc_hi[b] = crc[15-b];
    end
    ref_q.push_back(SB_DLE);
    foreach (body[i]) ref_q.push_back(body[i]);
    ref_q.push_back(crc_lo);
    ref_q.push_back(crc_hi);
    ref_q.push_back(SB_DLE);
    ref_q.push_back(SB_ETX);
  endfunction

  // Raises the chosen requests and queues each frame as its handshake completes
  task automatic issue_request(input logic do_lt, input logic do_at, input logic lane,
                               input logic rsp, input logic rw, input logic [7:0] addr,
                               input logic [6:0] len, input logic [23:0] data);
    int   waited;
    logic lt_take;
    logic at_take;
    waited = 0;
    @(negedge ELEC_vif);
    lt_lane       = lane;
    at_rsp        = rsp;
    at_read_write = rw;
    at_address    = addr;
    at_len        = len;
    at_data       = data;
    lt_valid      = do_lt;
    at_valid      = do_at;
    while ((lt_valid || at_valid) && waited < wait_limit) begin
      lt_take = lt_valid && lt_ready;   // Taken at the coming rising edge
      at_take = at_valid && at_ready;
      @(negedge ELEC_vif);
      if (lt_take) begin
        lt_valid = 1'b0;
        sb_ref_frame(1'b1, lane, rsp, rw, addr, len, data);
        foreach (ref_q[i]) u_chk.exp_q.push_back(ref_q[i]);
      end
      if (at_take) begin
        at_valid = 1'b0;
        sb_ref_frame(1'b0, lane, rsp, rw, addr, len, data);
        foreach (ref_q[i]) u_chk.exp_q.push_back(ref_q[i]);
      end
      waited++;
    end
    if (lt_valid || at_valid) begin
      timeout_errs++;
      $display("Timeout: request not accepted within %0d cycles", wait_limit);
      lt_valid = 1'b0;
      at_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (u_chk.exp_q.size() != 0 && waited < wait_limit) begin
      @(negedge ELEC_vif);
      waited++;
    end
    if (u_chk.exp_q.size() != 0) begin
      timeout_errs++;
      $display("Timeout: %0d expected symbols never appeared on sbtx", u_chk.exp_q.size());
    end
    repeat (2 * SB_BIT_CYCLES) @(negedge ELEC_vif);   // Line back to idle
  endtask

  initial begin
    logic [31:0] fields;
    reset         = 1'b1;
    at_valid      = 1'b0;
    at_rsp        = 1'b0;
    at_read_write = 1'b0;
    at_address    = '0;
    at_len        = '0;
    at_data       = '0;
    lt_valid      = 1'b0;
    lt_lane       = 1'b0;
    repeat (10) @(negedge ELEC_vif);
    reset = 1'b0;
    repeat (20) @(negedge ELEC_vif);   // Idle line after reset

    issue_request(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 8'h3C, 7'h04, 24'h000000);   // Command
    issue_request(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 8'h3C, 7'h03, 24'h5A1234);   // Response
    issue_request(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 7'h00, 24'h000000);
    issue_request(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 8'h00, 7'h00, 24'h000000);
    wait_drain();

    // Both peers at once, LT frame goes first
    issue_request(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'h81, 7'h10, 24'h000000);
    wait_drain();

    for (int n = 0; n < 20; n++) begin
      rng    = xorshift32(rng);
      fields = rng;
      rng    = xorshift32(rng);
      issue_request(fields[0] && fields[1], !(fields[0] && fields[1]), fields[2], fields[3],
                    fields[4], fields[15:8], fields[22:16], rng[23:0]);
    end
    wait_drain();

    total_errs = timeout_errs + u_chk.sym_errs + u_chk.bit_errs + u_chk.dle_errs
               + u_chk.extra_errs + u_chk.ready_errs + u_dut.u_serializer.u_sva.fail_cnt;
    $display("Errors: symbol %0d, bit %0d, frame start %0d, unexpected %0d, ready %0d, %s%0d, %s%0d",
             u_chk.sym_errs, u_chk.bit_errs, u_chk.dle_errs, u_chk.extra_errs,
             u_chk.ready_errs, "assertion ", u_dut.u_serializer.u_sva.fail_cnt,
             "timeout ", timeout_errs);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sb_tx_top.sv
// Sideband transmitter; each request is held until its ready and only one frame is on the line
`timescale 1ns/100ps

module sb_tx_top (
  input  logic        ELEC_vif,
  input  logic        reset,
  // AT command or response request
  input  logic        at_valid,
  output logic        at_ready,
  input  logic        at_rsp,
  input  logic        at_read_write,
  input  logic [7:0]  at_address,
  input  logic [6:0]  at_len,
  input  logic [23:0] at_data,
  // LT_fall request
  input  logic        lt_valid,
  output logic        lt_ready,
  input  logic        lt_lane,
  output logic        sbtx
);

  sb_symbol_if at_sym ();
  sb_symbol_if lt_sym ();
  sb_symbol_if ser_sym ();

  sb_at_framer u_at_framer (
    .ELEC_vif      (ELEC_vif),
    .reset         (reset),
    .at_valid      (at_valid),
    .at_ready      (at_ready),
    .at_rsp        (at_rsp),
    .at_read_write (at_read_write),
    .at_address    (at_address),
    .at_len        (at_len),
    .at_data       (at_data),
    .sym           (at_sym.producer)
  );

  sb_lt_framer u_lt_framer (
    .ELEC_vif (ELEC_vif),
    .reset    (reset),
    .lt_valid (lt_valid),
    .lt_ready (lt_ready),
    .lt_lane  (lt_lane),
    .sym      (lt_sym.producer)
  );

  sb_arbiter u_arbiter (
    .ELEC_vif (ELEC_vif),
    .reset    (reset),
    .at_sym   (at_sym.consumer),
    .lt_sym   (lt_sym.consumer),
    .ser_sym  (ser_sym.producer)
  );

  sb_serializer u_serializer (
    .ELEC_vif (ELEC_vif),
    .reset    (reset),
    .sym      (ser_sym.consumer),
    .sbtx     (sbtx)
  );

endmodule
